//--- hw/llki_msg_pkg.sv
// Key-loading message definitions: IDs, status codes, header layout and FSM states
package llki_msg_pkg;

  // Width of the length field, which counts the header word too
  localparam int MSG_LEN_W = 16;

  // ------------------------------
  // Message IDs, carried in the low byte of every header
  // ------------------------------
  typedef enum logic [7:0] {
    // Host requests
    MID_LOAD_KEY_REQ    = 8'h00,
    MID_CLEAR_KEY_REQ   = 8'h01,
    MID_KEY_STATUS_REQ  = 8'h02,
    // Responses back to the host
    MID_LOAD_KEY_ACK    = 8'h03,
    MID_CLEAR_KEY_ACK   = 8'h04,
    MID_KEY_STATUS_RESP = 8'h05,
    MID_ERROR_RESP      = 8'h06
  } llki_msg_id_e;

  // ------------------------------
  // Status codes
  // ------------------------------
  typedef enum logic [7:0] {
    STS_GOOD            = 8'h00,
    STS_KEY_PRESENT     = 8'h01,
    STS_KEY_NOT_PRESENT = 8'h02,
    // Error codes sit apart from the normal ones
    STS_BAD_MSG_ID      = 8'h20,
    STS_BAD_MSG_LEN     = 8'h21,
    STS_KEY_OVERWRITE   = 8'h22,
    STS_LOSS_OF_SYNC    = 8'h23,
    STS_BAD_KEY_LEN     = 8'h24
  } llki_status_e;

  // Header word, same layout for requests and responses
  typedef struct packed {
    logic [MSG_LEN_W-1:0] msg_len;
    llki_status_e         status;
    llki_msg_id_e         msg_id;
  } llki_msg_hdr_t;

  // Protocol FSM states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MSG_CHECK,
    ST_LOAD_KEY_WORDS,
    ST_WAIT_COMPLETE,
    ST_CLEAR_KEY,
    ST_RESPONSE
  } llki_state_e;

endpackage

//--- hw/llki_bus_pkg.sv
// Register bus and core key port types plus control/status bit map
package llki_bus_pkg;

  // Register bus widths
  localparam int BUS_AW = 32;
  localparam int BUS_DW = 32;

  // Host side request, strobes are one cycle wide
  typedef struct packed {
    logic              we;
    logic              re;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
  } reg_req_t;

  // Response, returned one cycle after the strobe
  typedef struct packed {
    logic              ack;
    logic              error;
    logic [BUS_DW-1:0] rdata;
  } reg_rsp_t;

  // ------------------------------
  // Discrete key port of the core
  // ------------------------------
  typedef struct packed {
    logic [BUS_DW-1:0] key_data;
    logic              key_valid;
    logic              clear_key;
  } key_out_t;

  typedef struct packed {
    logic key_ready;
    logic key_complete;
    logic clear_key_ack;
  } key_in_t;

  // Control/status register bit positions
  localparam int CTRLSTS_RESP_WAITING_BIT  = 0;
  localparam int CTRLSTS_READY_FOR_KEY_BIT = 1;

endpackage

//--- hw/llki_key_word_counter.sv
// Counter of the key words still due in a load-key message
`timescale 1ns/1ns

module llki_key_word_counter (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               load_i,
  input  logic [llki_msg_pkg::MSG_LEN_W-1:0] len_i,
  input  logic                               dec_i,
  output logic                               last_o
);

  // Length counts the header, so two left means one key word to go
  localparam logic [llki_msg_pkg::MSG_LEN_W-1:0] LAST_CNT = 2;

  logic [llki_msg_pkg::MSG_LEN_W-1:0] cnt_q;

  // ------------------------------
  // Remaining word count
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= len_i;
    end else if (dec_i && (cnt_q != '0)) begin
      // Never wraps below zero
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last_o = (cnt_q == LAST_CNT);

endmodule

//--- hw/llki_reg_decode.sv
// Register bus decode with control/status register, read mux and bus response
`timescale 1ns/1ns

module llki_reg_decode #(
  parameter logic [llki_bus_pkg::BUS_AW-1:0] CTRLSTS_ADDR  = '0,
  parameter logic [llki_bus_pkg::BUS_AW-1:0] SENDRECV_ADDR = '0
) (
  input  logic                             clk,
  input  logic                             rst,
  // Host register bus
  input  llki_bus_pkg::reg_req_t           req_i,
  output llki_bus_pkg::reg_rsp_t           rsp_o,
  // Status sources
  input  logic                             key_ready_i,
  input  logic                             resp_waiting_i,
  input  llki_msg_pkg::llki_msg_hdr_t      resp_word_i,
  // Pulses toward the protocol FSM
  output logic                             msg_wr_o,
  output logic [llki_bus_pkg::BUS_DW-1:0]  msg_data_o,
  output logic                             resp_rd_o
);

  // Address hits
  logic hit_ctrl;
  logic hit_sr;
  logic access;

  // Registered bus response
  logic                            ack_q;
  logic                            err_q;
  logic [llki_bus_pkg::BUS_DW-1:0] rdata_q;
  logic [llki_bus_pkg::BUS_DW-1:0] rdata_d;

  // Two flag control/status register
  logic [1:0] ctrlsts_q;

  assign hit_ctrl = (req_i.addr == CTRLSTS_ADDR);
  assign hit_sr   = (req_i.addr == SENDRECV_ADDR);
  assign access   = req_i.we | req_i.re;

  // ------------------------------
  // Send/receive pulses
  // ------------------------------
  // Header and key words go straight to the FSM, no buffering of key material
  assign msg_wr_o   = req_i.we & hit_sr;
  assign msg_data_o = req_i.wdata;
  // Reading the response word releases the FSM
  assign resp_rd_o  = req_i.re & hit_sr;

  // ------------------------------
  // Control/status and bus response
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrlsts_q <= '0;
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      // Flags follow their sources one cycle late
      ctrlsts_q[llki_bus_pkg::CTRLSTS_RESP_WAITING_BIT]  <= resp_waiting_i;
      ctrlsts_q[llki_bus_pkg::CTRLSTS_READY_FOR_KEY_BIT] <= key_ready_i;
      // Every strobe is acknowledged on the next cycle
      ack_q <= access;
      // Unmapped address, flagged with the acknowledge
      err_q <= access & ~(hit_ctrl | hit_sr);
    end
  end

  // Read mux
  always_comb begin
    rdata_d = '0;
    if (hit_ctrl) begin
      rdata_d[1:0] = ctrlsts_q;
    end else if (hit_sr) begin
      rdata_d = resp_word_i;
    end
  end

  // Read data only moves on a read strobe
  always_ff @(posedge clk) begin
    if (req_i.re) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o.ack   = ack_q;
  assign rsp_o.error = err_q;
  assign rsp_o.rdata = rdata_q;

endmodule

//--- hw/llki_pp_fsm.sv
// Protocol FSM: checks requests, steers key words and clears, builds responses
`timescale 1ns/1ns

module llki_pp_fsm (
  input  logic                                 clk,
  input  logic                                 rst,
  // From the register decode
  input  logic                                 msg_wr_i,
  input  logic [llki_bus_pkg::BUS_DW-1:0]      msg_data_i,
  input  logic                                 resp_rd_i,
  // Core key port
  input  llki_bus_pkg::key_in_t                key_i,
  output llki_bus_pkg::key_out_t               key_o,
  // Key word counter
  output logic                                 cnt_load_o,
  output logic [llki_msg_pkg::MSG_LEN_W-1:0]   cnt_len_o,
  output logic                                 cnt_dec_o,
  input  logic                                 cnt_last_i,
  // Response toward the host
  output logic                                 resp_waiting_o,
  output llki_msg_pkg::llki_msg_hdr_t          resp_word_o
);

  // All responses are a single header word
  localparam logic [llki_msg_pkg::MSG_LEN_W-1:0] RESP_LEN = 1;

  llki_msg_pkg::llki_state_e       state_q;
  llki_msg_pkg::llki_state_e       state_d;
  // Request header that is later reused for the response ID and status
  llki_msg_pkg::llki_msg_hdr_t     hdr_q;
  llki_msg_pkg::llki_msg_hdr_t     hdr_d;
  logic                            key_valid_q;
  logic                            key_valid_d;
  logic [llki_bus_pkg::BUS_DW-1:0] key_data_q;
  logic [llki_bus_pkg::BUS_DW-1:0] key_data_d;

  // Response header from an ID and a status code
  function automatic llki_msg_pkg::llki_msg_hdr_t mk_hdr(
    input llki_msg_pkg::llki_msg_id_e id,
    input llki_msg_pkg::llki_status_e code
  );
    llki_msg_pkg::llki_msg_hdr_t h;
    h.msg_len = RESP_LEN;
    h.status  = code;
    h.msg_id  = id;
    return h;
  endfunction

  // ------------------------------
  // Next state logic
  // ------------------------------
  always_comb begin
    state_d     = state_q;
    hdr_d       = hdr_q;
    key_valid_d = 1'b0;
    key_data_d  = key_data_q;
    cnt_load_o  = 1'b0;
    cnt_dec_o   = 1'b0;

    case (state_q)
      llki_msg_pkg::ST_IDLE: begin
        // Capture the header for the check on the next cycle
        if (msg_wr_i) begin
          hdr_d   = llki_msg_pkg::llki_msg_hdr_t'(msg_data_i);
          state_d = llki_msg_pkg::ST_MSG_CHECK;
        end
      end

      llki_msg_pkg::ST_MSG_CHECK: begin
        state_d = llki_msg_pkg::ST_RESPONSE;
        case (hdr_q.msg_id)
          llki_msg_pkg::MID_LOAD_KEY_REQ: begin
            // Need the header plus at least one key word
            if (hdr_q.msg_len < 2) begin
              hdr_d = mk_hdr(llki_msg_pkg::MID_ERROR_RESP, llki_msg_pkg::STS_BAD_MSG_LEN);
            end else if (key_i.key_complete) begin
              hdr_d = mk_hdr(llki_msg_pkg::MID_ERROR_RESP, llki_msg_pkg::STS_KEY_OVERWRITE);
            end else begin
              // Arm the counter with the full length
              cnt_load_o = 1'b1;
              state_d    = llki_msg_pkg::ST_LOAD_KEY_WORDS;
            end
          end
          llki_msg_pkg::MID_CLEAR_KEY_REQ: begin
            if (hdr_q.msg_len != 1) begin
              hdr_d = mk_hdr(llki_msg_pkg::MID_ERROR_RESP, llki_msg_pkg::STS_BAD_MSG_LEN);
            end else begin
              state_d = llki_msg_pkg::ST_CLEAR_KEY;
            end
          end
          llki_msg_pkg::MID_KEY_STATUS_REQ: begin
            if (hdr_q.msg_len != 1) begin
              hdr_d = mk_hdr(llki_msg_pkg::MID_ERROR_RESP, llki_msg_pkg::STS_BAD_MSG_LEN);
            end else if (key_i.key_complete) begin
              hdr_d = mk_hdr(llki_msg_pkg::MID_KEY_STATUS_RESP,
                             llki_msg_pkg::STS_KEY_PRESENT);
            end else begin
              hdr_d = mk_hdr(llki_msg_pkg::MID_KEY_STATUS_RESP,
                             llki_msg_pkg::STS_KEY_NOT_PRESENT);
            end
          end
          default: begin
            hdr_d = mk_hdr(llki_msg_pkg::MID_ERROR_RESP, llki_msg_pkg::STS_BAD_MSG_ID);
          end
        endcase
      end

      llki_msg_pkg::ST_LOAD_KEY_WORDS: begin
        if (msg_wr_i) begin
          if (!key_i.key_ready) begin
            // Core not ready so the word is dropped
            hdr_d   = mk_hdr(llki_msg_pkg::MID_ERROR_RESP, llki_msg_pkg::STS_LOSS_OF_SYNC);
            state_d = llki_msg_pkg::ST_RESPONSE;
          end else if (key_i.key_complete) begin
            // Too many words for this core so wipe what it holds
            hdr_d   = mk_hdr(llki_msg_pkg::MID_ERROR_RESP, llki_msg_pkg::STS_BAD_KEY_LEN);
            state_d = llki_msg_pkg::ST_CLEAR_KEY;
          end else begin
            key_data_d  = msg_data_i;
            key_valid_d = 1'b1;
            cnt_dec_o   = 1'b1;
            // Last word sent while the core still has to finish
            if (cnt_last_i) begin
              hdr_d   = mk_hdr(llki_msg_pkg::MID_LOAD_KEY_ACK, llki_msg_pkg::STS_GOOD);
              state_d = llki_msg_pkg::ST_WAIT_COMPLETE;
            end
          end
        end
      end

      llki_msg_pkg::ST_WAIT_COMPLETE: begin
        if (key_i.key_complete) begin
          state_d = llki_msg_pkg::ST_RESPONSE;
        end
      end

      llki_msg_pkg::ST_CLEAR_KEY: begin
        if (key_i.clear_key_ack) begin
          // An error code picked up on the way here is kept
          if (hdr_q.msg_id != llki_msg_pkg::MID_ERROR_RESP) begin
            hdr_d = mk_hdr(llki_msg_pkg::MID_CLEAR_KEY_ACK, llki_msg_pkg::STS_GOOD);
          end
          state_d = llki_msg_pkg::ST_RESPONSE;
        end
      end

      llki_msg_pkg::ST_RESPONSE: begin
        // Host read of send/receive ends the message
        if (resp_rd_i) begin
          state_d = llki_msg_pkg::ST_IDLE;
        end
      end

      default: begin
        state_d = llki_msg_pkg::ST_IDLE;
      end
    endcase
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q     <= llki_msg_pkg::ST_IDLE;
      key_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      key_valid_q <= key_valid_d;
    end
  end

  // Header and key word
  always_ff @(posedge clk) begin
    hdr_q      <= hdr_d;
    key_data_q <= key_data_d;
  end

  // Counter starts from the request length
  assign cnt_len_o = hdr_q.msg_len;

  // Core side
  assign key_o.key_data  = key_data_q;
  assign key_o.key_valid = key_valid_q;
  // Held until the core acknowledges
  assign key_o.clear_key = (state_q == llki_msg_pkg::ST_CLEAR_KEY);

  // Response word is valid while waiting
  assign resp_waiting_o = (state_q == llki_msg_pkg::ST_RESPONSE);
  always_comb begin
    resp_word_o         = hdr_q;
    resp_word_o.msg_len = RESP_LEN;
  end

endmodule

//--- hw/llki_pp_top.sv
// Key-loading protocol processor between a register bus and a core key port
`timescale 1ns/1ns

module llki_pp_top #(
  parameter logic [llki_bus_pkg::BUS_AW-1:0] CTRLSTS_ADDR  = 32'h0000_0000,
  parameter logic [llki_bus_pkg::BUS_AW-1:0] SENDRECV_ADDR = 32'h0000_0008
) (
  input  logic                   clk,
  input  logic                   rst,
  // Host register bus
  input  llki_bus_pkg::reg_req_t req_i,
  output llki_bus_pkg::reg_rsp_t rsp_o,
  // Core key port
  input  llki_bus_pkg::key_in_t  key_i,
  output llki_bus_pkg::key_out_t key_o
);

  // Decode to FSM
  logic                               msg_wr;
  logic [llki_bus_pkg::BUS_DW-1:0]    msg_data;
  logic                               resp_rd;
  // FSM to decode
  logic                               resp_waiting;
  llki_msg_pkg::llki_msg_hdr_t        resp_word;
  // FSM and counter
  logic                               cnt_load;
  logic [llki_msg_pkg::MSG_LEN_W-1:0] cnt_len;
  logic                               cnt_dec;
  logic                               cnt_last;

  // ------------------------------
  // Register decode
  // ------------------------------
  llki_reg_decode #(
    .CTRLSTS_ADDR  (CTRLSTS_ADDR),
    .SENDRECV_ADDR (SENDRECV_ADDR)
  ) i_llki_reg_decode (
    .clk            (clk),
    .rst            (rst),
    .req_i          (req_i),
    .rsp_o          (rsp_o),
    .key_ready_i    (key_i.key_ready),
    .resp_waiting_i (resp_waiting),
    .resp_word_i    (resp_word),
    .msg_wr_o       (msg_wr),
    .msg_data_o     (msg_data),
    .resp_rd_o      (resp_rd)
  );

  // ------------------------------
  // Protocol FSM
  // ------------------------------
  llki_pp_fsm i_llki_pp_fsm (
    .clk            (clk),
    .rst            (rst),
    .msg_wr_i       (msg_wr),
    .msg_data_i     (msg_data),
    .resp_rd_i      (resp_rd),
    .key_i          (key_i),
    .key_o          (key_o),
    .cnt_load_o     (cnt_load),
    .cnt_len_o      (cnt_len),
    .cnt_dec_o      (cnt_dec),
    .cnt_last_i     (cnt_last),
    .resp_waiting_o (resp_waiting),
    .resp_word_o    (resp_word)
  );

  // Key words still due
  llki_key_word_counter i_llki_key_word_counter (
    .clk    (clk),
    .rst    (rst),
    .load_i (cnt_load),
    .len_i  (cnt_len),
    .dec_i  (cnt_dec),
    .last_o (cnt_last)
  );

endmodule

//--- testbench/tb_core_key_model.sv
// Behavioral core key port: takes key words, signals complete, answers clears
`timescale 1ns/1ns

module tb_core_key_model #(
  parameter int KEY_WORDS = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  // From the processor
  input  llki_bus_pkg::key_out_t key_i,
  // Back to the processor
  output llki_bus_pkg::key_in_t  key_o,
  // Holds key ready low while set
  input  logic                   stall_i
);

  localparam int MAX_WORDS = 8;

  // Received key words, in arrival order
  logic [llki_bus_pkg::BUS_DW-1:0] key_mem [MAX_WORDS];
  int   word_cnt;
  int   clear_cnt;
  int   clr_wait;
  logic complete_q;
  logic clear_ack_q;

  assign key_o.key_ready     = ~stall_i;
  assign key_o.key_complete  = complete_q;
  assign key_o.clear_key_ack = clear_ack_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      word_cnt    <= 0;
      clear_cnt   <= 0;
      clr_wait    <= 0;
      complete_q  <= 1'b0;
      clear_ack_q <= 1'b0;
    end else begin
      // Ack is a single cycle pulse
      clear_ack_q <= 1'b0;
      if (key_i.clear_key && !clear_ack_q) begin
        // Second cycle of the request, drop the key and answer
        if (clr_wait == 1) begin
          clear_ack_q <= 1'b1;
          clr_wait    <= 0;
          word_cnt    <= 0;
          complete_q  <= 1'b0;
          clear_cnt   <= clear_cnt + 1;
        end else begin
          clr_wait <= clr_wait + 1;
        end
      end else if (key_i.key_valid) begin
        word_cnt <= word_cnt + 1;
        // Full key length reached
        if (word_cnt == KEY_WORDS - 1) begin
          complete_q <= 1'b1;
        end
      end
    end
  end

  // Key storage
  always_ff @(posedge clk) begin
    if (key_i.key_valid && !key_i.clear_key && (word_cnt < MAX_WORDS)) begin
      key_mem[word_cnt] <= key_i.key_data;
    end
  end

endmodule

//--- testbench/tb_llki_pp.sv
// Directed testbench for the key-loading protocol processor and a model core
`timescale 1ns/1ns

module tb_llki_pp;

  localparam logic [31:0] CTRLSTS_ADDR  = 32'h0000_0000;
  localparam logic [31:0] SENDRECV_ADDR = 32'h0000_0008;
  localparam logic [31:0] UNMAPPED_ADDR = 32'h0000_0040;
  localparam int KEY_WORDS    = 4;
  localparam int ACK_TIMEOUT  = 20;
  localparam int POLL_TIMEOUT = 60;
  localparam int WB = llki_bus_pkg::CTRLSTS_RESP_WAITING_BIT;
  localparam int RB = llki_bus_pkg::CTRLSTS_READY_FOR_KEY_BIT;

  logic                   clk;
  logic                   rst;
  logic                   stall;
  llki_bus_pkg::reg_req_t req;
  llki_bus_pkg::reg_rsp_t rsp;
  llki_bus_pkg::key_in_t  core_in;
  llki_bus_pkg::key_out_t core_out;

  int          mismatches;
  int          timeouts;
  logic [31:0] rng_state;
  string       test_name;

  llki_pp_top #(
    .CTRLSTS_ADDR  (CTRLSTS_ADDR),
    .SENDRECV_ADDR (SENDRECV_ADDR)
  ) i_llki_pp_top (
    .clk   (clk),
    .rst   (rst),
    .req_i (req),
    .rsp_o (rsp),
    .key_i (core_in),
    .key_o (core_out)
  );

  tb_core_key_model #(
    .KEY_WORDS (KEY_WORDS)
  ) i_core_key_model (
    .clk     (clk),
    .rst     (rst),
    .key_i   (core_out),
    .key_o   (core_in),
    .stall_i (stall)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------
  // Helpers and compare tasks
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Header word built field by field
  function automatic llki_msg_pkg::llki_msg_hdr_t make_hdr(
    input logic [15:0]                len,
    input llki_msg_pkg::llki_status_e code,
    input llki_msg_pkg::llki_msg_id_e id
  );
    llki_msg_pkg::llki_msg_hdr_t h;
    h.msg_len = len;
    h.status  = code;
    h.msg_id  = id;
    return h;
  endfunction

  task automatic check_hdr(input string what, input llki_msg_pkg::llki_msg_hdr_t exp,
                           input llki_msg_pkg::llki_msg_hdr_t act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
      mismatches++;
    end
  endtask

  // ------------------------------
  // Register bus access
  // ------------------------------
  // Each access starts and ends on a falling edge
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
    int n;
    req.we    = 1'b1;
    req.re    = 1'b0;
    req.addr  = addr;
    req.wdata = data;
    @(negedge clk);
    req.we = 1'b0;
    // Acknowledge is due one cycle after the strobe
    check_bit("write ack", 1'b1, rsp.ack);
    n = 0;
    while (!rsp.ack && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    err = rsp.error;
    if (!rsp.ack) begin
      $display("In %s the write to address %h was never acknowledged", test_name, addr);
      timeouts++;
    end
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    int n;
    req.we   = 1'b0;
    req.re   = 1'b1;
    req.addr = addr;
    @(negedge clk);
    req.re = 1'b0;
    check_bit("read ack", 1'b1, rsp.ack);
    n = 0;
    while (!rsp.ack && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    data = rsp.rdata;
    err  = rsp.error;
    if (!rsp.ack) begin
      $display("In %s the read of address %h was never acknowledged", test_name, addr);
      timeouts++;
    end
  endtask

  // Poll control/status until response waiting matches and ready is set if needed
  task automatic wait_flags(input logic want_waiting, input logic need_ready);
    logic [31:0] data;
    logic        err;
    int          n;
    n = 0;
    bus_read(CTRLSTS_ADDR, data, err);
    while ((data[WB] !== want_waiting || (need_ready && data[RB] !== 1'b1))
           && n < POLL_TIMEOUT) begin
      bus_read(CTRLSTS_ADDR, data, err);
      n++;
    end
    if (data[WB] !== want_waiting || (need_ready && data[RB] !== 1'b1)) begin
      $display("In %s the status register never showed waiting=%b", test_name, want_waiting);
      timeouts++;
    end
    check_bit("status read error", 1'b0, err);
  endtask

  task automatic send_request(input logic [15:0] len, input llki_msg_pkg::llki_msg_id_e id);
    logic err;
    wait_flags(1'b0, 1'b1);
    bus_write(SENDRECV_ADDR, make_hdr(len, llki_msg_pkg::STS_GOOD, id), err);
    check_bit("header write error", 1'b0, err);
  endtask

  task automatic send_key_word(input logic [31:0] data);
    logic err;
    wait_flags(1'b0, 1'b1);
    bus_write(SENDRECV_ADDR, data, err);
    check_bit("key word write error", 1'b0, err);
  endtask

  // Collect the response word and expect the waiting flag to drop
  task automatic get_response(input llki_msg_pkg::llki_msg_hdr_t exp);
    logic [31:0] data;
    logic        err;
    wait_flags(1'b1, 1'b0);
    bus_read(SENDRECV_ADDR, data, err);
    check_bit("response read error", 1'b0, err);
    check_hdr("response", exp, llki_msg_pkg::llki_msg_hdr_t'(data));
    wait_flags(1'b0, 1'b0);
  endtask

  task automatic status_request(input llki_msg_pkg::llki_status_e code);
    send_request(16'd1, llki_msg_pkg::MID_KEY_STATUS_REQ);
    get_response(make_hdr(16'd1, code, llki_msg_pkg::MID_KEY_STATUS_RESP));
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_reset_decode();
    logic [31:0] data;
    logic        err;
    test_name = "reset_decode";
    bus_read(CTRLSTS_ADDR, data, err);
    check_bit("ctrlsts error", 1'b0, err);
    check_bit("ready for key", 1'b1, data[RB]);
    check_bit("response waiting", 1'b0, data[WB]);
    bus_write(UNMAPPED_ADDR, 32'h1234_5678, err);
    check_bit("unmapped write error", 1'b1, err);
    bus_read(UNMAPPED_ADDR + 32'd4, data, err);
    check_bit("unmapped read error", 1'b1, err);
  endtask

  task automatic test_status_no_key();
    test_name = "status_no_key";
    status_request(llki_msg_pkg::STS_KEY_NOT_PRESENT);
  endtask

  task automatic test_key_load();
    logic [31:0] words [KEY_WORDS];
    test_name = "key_load";
    for (int i = 0; i < KEY_WORDS; i++) begin
      rng_state = xorshift32(rng_state);
      words[i]  = rng_state;
    end
    // Header plus four key words
    send_request(16'd5, llki_msg_pkg::MID_LOAD_KEY_REQ);
    for (int i = 0; i < KEY_WORDS; i++) begin
      send_key_word(words[i]);
    end
    get_response(make_hdr(16'd1, llki_msg_pkg::STS_GOOD, llki_msg_pkg::MID_LOAD_KEY_ACK));
    check_word("words at core", 32'(KEY_WORDS), 32'(i_core_key_model.word_cnt));
    for (int i = 0; i < KEY_WORDS; i++) begin
      check_word("key word", words[i], i_core_key_model.key_mem[i]);
    end
    status_request(llki_msg_pkg::STS_KEY_PRESENT);
  endtask

  task automatic test_header_errors();
    test_name = "header_errors";
    send_request(16'd5, llki_msg_pkg::MID_LOAD_KEY_REQ);
    get_response(make_hdr(16'd1, llki_msg_pkg::STS_KEY_OVERWRITE,
                          llki_msg_pkg::MID_ERROR_RESP));
    send_request(16'd2, llki_msg_pkg::MID_CLEAR_KEY_REQ);
    get_response(make_hdr(16'd1, llki_msg_pkg::STS_BAD_MSG_LEN, llki_msg_pkg::MID_ERROR_RESP));
    // ID outside the request set
    send_request(16'd1, llki_msg_pkg::llki_msg_id_e'(8'h7e));
    get_response(make_hdr(16'd1, llki_msg_pkg::STS_BAD_MSG_ID, llki_msg_pkg::MID_ERROR_RESP));
  endtask

  task automatic test_clear_key();
    int clears;
    test_name = "clear_key";
    clears = i_core_key_model.clear_cnt;
    send_request(16'd1, llki_msg_pkg::MID_CLEAR_KEY_REQ);
    get_response(make_hdr(16'd1, llki_msg_pkg::STS_GOOD, llki_msg_pkg::MID_CLEAR_KEY_ACK));
    check_word("clears at core", 32'(clears + 1), 32'(i_core_key_model.clear_cnt));
    status_request(llki_msg_pkg::STS_KEY_NOT_PRESENT);
  endtask

  task automatic test_key_word_errors();
    logic err;
    int   clears;
    test_name = "loss_of_sync";
    send_request(16'd5, llki_msg_pkg::MID_LOAD_KEY_REQ);
    wait_flags(1'b0, 1'b1);
    // Core stops being ready just before the first word
    stall = 1'b1;
    bus_write(SENDRECV_ADDR, xorshift32(rng_state), err);
    check_bit("key word write error", 1'b0, err);
    get_response(make_hdr(16'd1, llki_msg_pkg::STS_LOSS_OF_SYNC,
                          llki_msg_pkg::MID_ERROR_RESP));
    stall = 1'b0;
    check_word("words at core", 32'd0, 32'(i_core_key_model.word_cnt));

    test_name = "bad_key_length";
    clears = i_core_key_model.clear_cnt;
    // Six key words declared against a four word core
    send_request(16'd7, llki_msg_pkg::MID_LOAD_KEY_REQ);
    for (int i = 0; i < KEY_WORDS + 1; i++) begin
      rng_state = xorshift32(rng_state);
      send_key_word(rng_state);
    end
    get_response(make_hdr(16'd1, llki_msg_pkg::STS_BAD_KEY_LEN, llki_msg_pkg::MID_ERROR_RESP));
    check_word("clears at core", 32'(clears + 1), 32'(i_core_key_model.clear_cnt));
    status_request(llki_msg_pkg::STS_KEY_NOT_PRESENT);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    rst        = 1'b1;
    stall      = 1'b0;
    req        = '0;
    mismatches = 0;
    timeouts   = 0;
    rng_state  = 32'ha210_d5d1;
    test_name  = "reset";
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    test_reset_decode();
    test_status_no_key();
    test_key_load();
    test_header_errors();
    test_clear_key();
    test_key_word_errors();

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- build.f
hw/llki_msg_pkg.sv
hw/llki_bus_pkg.sv
hw/llki_key_word_counter.sv
hw/llki_reg_decode.sv
hw/llki_pp_fsm.sv
hw/llki_pp_top.sv
testbench/tb_core_key_model.sv
testbench/tb_llki_pp.sv

//--- Makefile
TOP := tb_llki_pp
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG)
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
